//--- common/mandel_pkg.sv
`default_nettype none

package mandel_pkg;

   // ========================================================================
   // Fixed-point format
   // ========================================================================

   // Signed Q4.12 coordinates
   localparam int WIDTH        = 16;
   localparam int FRAC_BITS    = WIDTH - 4;

   // 4.0 once a product has been shifted back by FRAC_BITS
   localparam int ESCAPE_LIMIT = 2 ** (WIDTH - 2);

   // ========================================================================
   // Iteration and grid
   // ========================================================================

   localparam int ITERS        = 32;
   localparam int ITER_W       = $clog2(ITERS);

   localparam int COLS         = 8;
   localparam int ROWS         = 6;
   localparam int COL_W        = $clog2(COLS);
   localparam int ROW_W        = $clog2(ROWS);

   localparam int SHADE_SHIFT  = 3;   // Spreads 5-bit counts over 8 bits

   // Wide enough to count every pixel of a frame as bounded
   localparam int CNT_W        = $clog2(COLS * ROWS + 1);

endpackage

`default_nettype wire

//--- design/escape_core.sv
`timescale 1ns/1ps
`default_nettype none

module escape_core (
   input  logic                                i_clk,
   input  logic                                i_nrst,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_c_re,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_c_im,
   input  logic                                i_run,
   output logic [mandel_pkg::ITER_W-1:0]       o_iter,
   output logic                                o_bounded,
   output logic                                o_done
);

   logic signed [mandel_pkg::WIDTH-1:0]   re_q;
   logic signed [mandel_pkg::WIDTH-1:0]   im_q;

   logic signed [2*mandel_pkg::WIDTH-1:0] re_prod;
   logic signed [2*mandel_pkg::WIDTH-1:0] im_prod;
   logic signed [2*mandel_pkg::WIDTH-1:0] cross_prod;
   logic signed [2*mandel_pkg::WIDTH-1:0] re_sq;
   logic signed [2*mandel_pkg::WIDTH-1:0] im_sq;
   logic signed [2*mandel_pkg::WIDTH-1:0] re_im;
   logic signed [2*mandel_pkg::WIDTH-1:0] re_calc;
   logic signed [2*mandel_pkg::WIDTH-1:0] im_calc;
   logic signed [2*mandel_pkg::WIDTH-1:0] mag;

   logic                                  escaped;
   logic                                  at_cap;
   logic                                  load;

   // ========================================================================
   // Squares and cross product, full width before the shift
   // ========================================================================

   assign re_prod    = re_q * re_q;
   assign im_prod    = im_q * im_q;
   assign cross_prod = re_q * im_q;

   assign re_sq      = re_prod >>> mandel_pkg::FRAC_BITS;
   assign im_sq      = im_prod >>> mandel_pkg::FRAC_BITS;
   assign re_im      = cross_prod >>> mandel_pkg::FRAC_BITS;

   // z*z + c, only the low WIDTH bits are kept in the registers
   assign re_calc    = re_sq - im_sq + i_c_re;
   assign im_calc    = (re_im <<< 1) + i_c_im;

   // Escape test runs on the untruncated squares
   assign mag        = re_sq + im_sq;
   assign escaped    = mag > mandel_pkg::ESCAPE_LIMIT;
   assign at_cap     = o_iter == mandel_pkg::ITER_W'(mandel_pkg::ITERS - 1);

   assign o_bounded  = ~escaped;
   assign o_done     = escaped | at_cap;

   // A finished point reloads so the core is ready for the next c
   assign load       = ~i_run | o_done;

   // ========================================================================
   // State
   // ========================================================================

   always_ff @(posedge i_clk) begin
      if (load) begin
         re_q <= i_c_re;
         im_q <= i_c_im;
      end else begin
         re_q <= re_calc[mandel_pkg::WIDTH-1:0];
         im_q <= im_calc[mandel_pkg::WIDTH-1:0];
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_iter <= '0;
      end else if (load) begin
         o_iter <= '0;
      end else begin
         o_iter <= o_iter + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- design/pixel_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_scanner (
   input  logic                                i_clk,
   input  logic                                i_nrst,
   input  logic                                i_start,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_x0,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_y0,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_step,
   input  logic                                i_core_done,
   output logic signed [mandel_pkg::WIDTH-1:0] o_c_re,
   output logic signed [mandel_pkg::WIDTH-1:0] o_c_im,
   output logic                                o_core_run,
   output logic [mandel_pkg::COL_W-1:0]        o_col,
   output logic [mandel_pkg::ROW_W-1:0]        o_row,
   output logic                                o_take,
   output logic                                o_frame_end,
   output logic                                o_busy
);

   // Sequencer is idle when busy is low, in the load cycle when busy is
   // high and run is low, and iterating when both are high
   logic                                busy_q;
   logic                                run_q;
   logic [mandel_pkg::COL_W-1:0]        col_q;
   logic [mandel_pkg::ROW_W-1:0]        row_q;

   logic signed [mandel_pkg::WIDTH-1:0] x0_q;
   logic signed [mandel_pkg::WIDTH-1:0] step_q;
   logic signed [mandel_pkg::WIDTH-1:0] c_re_q;
   logic signed [mandel_pkg::WIDTH-1:0] c_im_q;

   logic                                start_ok;
   logic                                take;
   logic                                last_col;
   logic                                last_row;

   assign start_ok = i_start & ~busy_q;   // A start during a frame is dropped
   assign take     = run_q & i_core_done;
   assign last_col = col_q == mandel_pkg::COL_W'(mandel_pkg::COLS - 1);
   assign last_row = row_q == mandel_pkg::ROW_W'(mandel_pkg::ROWS - 1);

   // ========================================================================
   // Sequencer and pixel counters
   // ========================================================================

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy_q <= 1'b0;
         run_q  <= 1'b0;
         col_q  <= '0;
         row_q  <= '0;
      end else if (!busy_q) begin
         if (start_ok) begin
            busy_q <= 1'b1;
            col_q  <= '0;
            row_q  <= '0;
         end
      end else if (!run_q) begin
         run_q <= 1'b1;   // Core has loaded z = c by now
      end else if (i_core_done) begin
         run_q <= 1'b0;
         if (last_col) begin
            col_q <= '0;
            if (last_row) begin
               busy_q <= 1'b0;
            end else begin
               row_q <= row_q + 1'b1;
            end
         end else begin
            col_q <= col_q + 1'b1;
         end
      end
   end

   // ========================================================================
   // Point c, stepped by addition
   // ========================================================================

   // c_re = x0 + col*step and c_im = y0 + row*step
   always_ff @(posedge i_clk) begin
      if (start_ok) begin
         x0_q   <= i_x0;
         step_q <= i_step;
         c_re_q <= i_x0;
         c_im_q <= i_y0;
      end else if (take) begin
         if (last_col) begin
            c_re_q <= x0_q;   // Back to the left edge
            c_im_q <= c_im_q + step_q;
         end else begin
            c_re_q <= c_re_q + step_q;
         end
      end
   end

   assign o_c_re      = c_re_q;
   assign o_c_im      = c_im_q;
   assign o_core_run  = run_q;
   assign o_col       = col_q;
   assign o_row       = row_q;
   assign o_take      = take;
   assign o_frame_end = take & last_col & last_row;
   assign o_busy      = busy_q;

endmodule

`default_nettype wire

//--- design/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_take,
   input  logic                          i_frame_end,
   input  logic [mandel_pkg::COL_W-1:0]  i_col,
   input  logic [mandel_pkg::ROW_W-1:0]  i_row,
   input  logic [mandel_pkg::ITER_W-1:0] i_iter,
   input  logic                          i_bounded,
   output logic                          o_pix_valid,
   output logic [mandel_pkg::COL_W-1:0]  o_pix_col,
   output logic [mandel_pkg::ROW_W-1:0]  o_pix_row,
   output logic [mandel_pkg::ITER_W-1:0] o_pix_iter,
   output logic                          o_pix_bounded,
   output logic [7:0]                    o_pix_shade,
   output logic                          o_frame_done,
   output logic [mandel_pkg::CNT_W-1:0]  o_inside_count
);

   logic [7:0]                   shade;
   logic [mandel_pkg::CNT_W-1:0] count_base;
   logic                         clear_pending;   // Next take opens a new frame

   // Bounded pixels are black, fast escapes are bright
   assign shade      = i_bounded ? 8'h00
                                 : 8'hff - (8'(i_iter) << mandel_pkg::SHADE_SHIFT);
   assign count_base = clear_pending ? '0 : o_inside_count;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_pix_valid    <= 1'b0;
         o_frame_done   <= 1'b0;
         o_inside_count <= '0;
         clear_pending  <= 1'b1;
         o_pix_col      <= '0;
         o_pix_row      <= '0;
         o_pix_iter     <= '0;
         o_pix_bounded  <= 1'b0;
         o_pix_shade    <= '0;
      end else begin
         o_pix_valid  <= i_take;
         o_frame_done <= i_frame_end;
         if (i_take) begin
            o_pix_col      <= i_col;
            o_pix_row      <= i_row;
            o_pix_iter     <= i_iter;
            o_pix_bounded  <= i_bounded;
            o_pix_shade    <= shade;
            o_inside_count <= count_base + mandel_pkg::CNT_W'(i_bounded);
            clear_pending  <= i_frame_end;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/mandel_top.sv
`timescale 1ns/1ps
`default_nettype none

module mandel_top (
   input  logic                                i_clk,
   input  logic                                i_nrst,
   input  logic                                i_start,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_x0,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_y0,
   input  logic signed [mandel_pkg::WIDTH-1:0] i_step,
   output logic                                o_busy,
   output logic                                o_pix_valid,
   output logic [mandel_pkg::COL_W-1:0]        o_pix_col,
   output logic [mandel_pkg::ROW_W-1:0]        o_pix_row,
   output logic [mandel_pkg::ITER_W-1:0]       o_pix_iter,
   output logic                                o_pix_bounded,
   output logic [7:0]                          o_pix_shade,
   output logic                                o_frame_done,
   output logic [mandel_pkg::CNT_W-1:0]        o_inside_count
);

   logic signed [mandel_pkg::WIDTH-1:0] c_re;
   logic signed [mandel_pkg::WIDTH-1:0] c_im;
   logic                                core_run;
   logic                                core_done;
   logic [mandel_pkg::ITER_W-1:0]       core_iter;
   logic                                core_bounded;
   logic                                pix_take;
   logic [mandel_pkg::COL_W-1:0]        scan_col;
   logic [mandel_pkg::ROW_W-1:0]        scan_row;
   logic                                frame_end;

   pixel_scanner u_scanner (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_start     (i_start),
      .i_x0        (i_x0),
      .i_y0        (i_y0),
      .i_step      (i_step),
      .i_core_done (core_done),
      .o_c_re      (c_re),
      .o_c_im      (c_im),
      .o_core_run  (core_run),
      .o_col       (scan_col),
      .o_row       (scan_row),
      .o_take      (pix_take),
      .o_frame_end (frame_end),
      .o_busy      (o_busy)
   );

   escape_core u_core (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_c_re    (c_re),
      .i_c_im    (c_im),
      .i_run     (core_run),
      .o_iter    (core_iter),
      .o_bounded (core_bounded),
      .o_done    (core_done)
   );

   result_stage u_result (
      .i_clk          (i_clk),
      .i_nrst         (i_nrst),
      .i_take         (pix_take),
      .i_frame_end    (frame_end),
      .i_col          (scan_col),
      .i_row          (scan_row),
      .i_iter         (core_iter),
      .i_bounded      (core_bounded),
      .o_pix_valid    (o_pix_valid),
      .o_pix_col      (o_pix_col),
      .o_pix_row      (o_pix_row),
      .o_pix_iter     (o_pix_iter),
      .o_pix_bounded  (o_pix_bounded),
      .o_pix_shade    (o_pix_shade),
      .o_frame_done   (o_frame_done),
      .o_inside_count (o_inside_count)
   );

endmodule

`default_nettype wire

//--- testbench/mandel_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mandel_chk (
   input logic                          i_clk,
   input logic                          i_nrst,
   input logic                          i_pix_valid,
   input logic                          i_frame_done,
   input logic [mandel_pkg::ITER_W-1:0] i_pix_iter,
   input logic                          i_pix_bounded
);

   // Strobes stay quiet for as long as reset is held
   a_quiet_in_reset : assert property (@(posedge i_clk)
      !i_nrst |-> !i_pix_valid && !i_frame_done)
      else $error("pixel or frame strobe while reset is low");

   a_done_with_pixel : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_frame_done |-> i_pix_valid)
      else $error("frame done without a pixel");

   a_iter_in_range : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_pix_valid |-> i_pix_iter <= mandel_pkg::ITER_W'(mandel_pkg::ITERS - 1))
      else $error("iteration count above the cap");

   a_bounded_at_cap : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_pix_valid && i_pix_bounded |-> i_pix_iter == mandel_pkg::ITER_W'(mandel_pkg::ITERS - 1))
      else $error("bounded pixel below the iteration cap");

endmodule

bind mandel_top mandel_chk u_chk (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_pix_valid   (o_pix_valid),
   .i_frame_done  (o_frame_done),
   .i_pix_iter    (o_pix_iter),
   .i_pix_bounded (o_pix_bounded)
);

`default_nettype wire

//--- testbench/tb_mandel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mandel;

   localparam int NUM_FRAMES = 5;
   localparam int NPIX       = mandel_pkg::COLS * mandel_pkg::ROWS;
   localparam int LIMIT      = NUM_FRAMES * NPIX * (mandel_pkg::ITERS + 2) + 200;

   logic                                i_clk;
   logic                                i_nrst;
   logic                                i_start;
   logic signed [mandel_pkg::WIDTH-1:0] i_x0;
   logic signed [mandel_pkg::WIDTH-1:0] i_y0;
   logic signed [mandel_pkg::WIDTH-1:0] i_step;
   logic                                o_busy;
   logic                                o_pix_valid;
   logic [mandel_pkg::COL_W-1:0]        o_pix_col;
   logic [mandel_pkg::ROW_W-1:0]        o_pix_row;
   logic [mandel_pkg::ITER_W-1:0]       o_pix_iter;
   logic                                o_pix_bounded;
   logic [7:0]                          o_pix_shade;
   logic                                o_frame_done;
   logic [mandel_pkg::CNT_W-1:0]        o_inside_count;

   // In the frame table an expected inside count of -1 leaves the count to the model
   string                               tab_name    [NUM_FRAMES];
   logic signed [mandel_pkg::WIDTH-1:0] tab_x0      [NUM_FRAMES];
   logic signed [mandel_pkg::WIDTH-1:0] tab_y0      [NUM_FRAMES];
   logic signed [mandel_pkg::WIDTH-1:0] tab_step    [NUM_FRAMES];
   int                                  tab_inside  [NUM_FRAMES];
   bit                                  tab_restart [NUM_FRAMES];

   int                                  errors;
   int                                  frame_errors;
   int                                  cycles;
   logic [31:0]                         rnd;

   mandel_top u_dut (
      .i_clk          (i_clk),
      .i_nrst         (i_nrst),
      .i_start        (i_start),
      .i_x0           (i_x0),
      .i_y0           (i_y0),
      .i_step         (i_step),
      .o_busy         (o_busy),
      .o_pix_valid    (o_pix_valid),
      .o_pix_col      (o_pix_col),
      .o_pix_row      (o_pix_row),
      .o_pix_iter     (o_pix_iter),
      .o_pix_bounded  (o_pix_bounded),
      .o_pix_shade    (o_pix_shade),
      .o_frame_done   (o_frame_done),
      .o_inside_count (o_inside_count)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycles = cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout after %0d cycles, the frame never finished", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // ========================================================================
   // Reference model
   // ========================================================================

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Escape count of one point in Q4.12 with products shifted back before use
   function automatic void escape_model(input logic signed [15:0] cre,
                                        input logic signed [15:0] cim,
                                        output int n, output bit bounded);
      logic signed [15:0] re;
      logic signed [15:0] im;
      longint             rr;
      longint             ii;
      longint             ri;
      re      = cre;
      im      = cim;
      n       = 0;
      bounded = 1'b1;
      forever begin
         rr = (longint'(re) * longint'(re)) >>> mandel_pkg::FRAC_BITS;
         ii = (longint'(im) * longint'(im)) >>> mandel_pkg::FRAC_BITS;
         ri = (longint'(re) * longint'(im)) >>> mandel_pkg::FRAC_BITS;
         if (rr + ii > longint'(mandel_pkg::ESCAPE_LIMIT)) begin
            bounded = 1'b0;
            return;
         end
         if (n == mandel_pkg::ITERS - 1) return;
         re = 16'(rr - ii + longint'(cre));
         im = 16'(2 * ri + longint'(cim));
         n  = n + 1;
      end
   endfunction

   function automatic int expected_shade(input int n, input bit bounded);
      return bounded ? 0 : (255 - (n << mandel_pkg::SHADE_SHIFT)) & 255;
   endfunction

   task automatic check_value(input string test, input string what,
                              input int expected, input int actual);
      assert (expected == actual) else begin
         $display("FAIL %s %s: expected %0d, actual %0d", test, what, expected, actual);
         errors       = errors + 1;
         frame_errors = frame_errors + 1;
      end
   endtask

   // ========================================================================
   // One frame with outputs sampled mid-cycle
   // ========================================================================

   task automatic run_frame(input int f);
      int                 idx;
      int                 col;
      int                 row;
      int                 n;
      int                 model_inside;
      bit                 bnd;
      bit                 done;
      bit                 pulsed;
      logic signed [15:0] cre;
      logic signed [15:0] cim;
      idx          = 0;
      model_inside = 0;
      done         = 1'b0;
      pulsed       = 1'b0;
      frame_errors = 0;
      @(posedge i_clk);
      #2;
      i_x0    = tab_x0[f];
      i_y0    = tab_y0[f];
      i_step  = tab_step[f];
      i_start = 1'b1;
      @(posedge i_clk);
      #2;
      i_start = 1'b0;
      #8;
      check_value(tab_name[f], "busy after start", 1, int'(o_busy));
      while (!done) begin
         if (o_pix_valid) begin
            col = idx % mandel_pkg::COLS;
            row = idx / mandel_pkg::COLS;
            cre = 16'(int'(tab_x0[f]) + col * int'(tab_step[f]));
            cim = 16'(int'(tab_y0[f]) + row * int'(tab_step[f]));
            escape_model(cre, cim, n, bnd);
            model_inside = model_inside + int'(bnd);
            check_value(tab_name[f], "col", col, int'(o_pix_col));
            check_value(tab_name[f], "row", row, int'(o_pix_row));
            check_value(tab_name[f], "iter", n, int'(o_pix_iter));
            check_value(tab_name[f], "bounded", int'(bnd), int'(o_pix_bounded));
            check_value(tab_name[f], "shade", expected_shade(n, bnd), int'(o_pix_shade));
            check_value(tab_name[f], "frame done", int'(idx == NPIX - 1), int'(o_frame_done));
            check_value(tab_name[f], "busy", int'(idx != NPIX - 1), int'(o_busy));
            idx = idx + 1;
         end else begin
            assert (!o_frame_done) else begin
               $display("Frame done in %s came without a pixel", tab_name[f]);
               errors = errors + 1;
               frame_errors = frame_errors + 1;
            end
         end
         if (o_frame_done) begin
            done = 1'b1;
            check_value(tab_name[f], "pixel total", NPIX, idx);
            check_value(tab_name[f], "inside count", model_inside, int'(o_inside_count));
            if (tab_inside[f] >= 0) begin
               check_value(tab_name[f], "inside by hand", tab_inside[f], int'(o_inside_count));
            end
         end
         @(posedge i_clk);
         #2;
         // A second start in mid frame carries other values on the inputs
         if (tab_restart[f] && idx == 10 && !pulsed) begin
            i_start = 1'b1;
            i_x0    = 16'sh3000;
            i_y0    = 16'sh1000;
            i_step  = 16'sh0100;
            pulsed  = 1'b1;
         end else begin
            i_start = 1'b0;
         end
         #8;
      end
      $display("Frame %s: %0d pixels, %0d errors", tab_name[f], idx, frame_errors);
   endtask

   initial begin
      i_nrst       = 1'b0;
      i_start      = 1'b0;
      i_x0         = '0;
      i_y0         = '0;
      i_step       = '0;
      errors       = 0;
      frame_errors = 0;
      cycles       = 0;
      tab_name[0] = "inside";
      tab_x0[0] = -16'sd2076;
      tab_y0[0] = -16'sd20;
      tab_step[0] = 16'sd8;
      tab_inside[0] = NPIX;
      tab_restart[0] = 1'b0;
      tab_name[1] = "outside";
      tab_x0[1] = 16'sd12288;   // 3.0
      tab_y0[1] = 16'sd0;
      tab_step[1] = 16'sd16;
      tab_inside[1] = 0;
      tab_restart[1] = 1'b0;
      tab_name[2] = "edge";
      tab_x0[2] = -16'sd8192;
      tab_y0[2] = -16'sd5120;
      tab_step[2] = 16'sd2048;
      tab_inside[2] = -1;
      tab_restart[2] = 1'b0;
      tab_name[3] = "restart";
      tab_x0[3] = -16'sd6144;
      tab_y0[3] = -16'sd3072;
      tab_step[3] = 16'sd1024;
      tab_inside[3] = -1;
      tab_restart[3] = 1'b1;
      rnd = 32'd8;
      rnd = xorshift(rnd);
      tab_x0[4] = 16'(-8192 + int'(rnd % 32'd6144));
      rnd = xorshift(rnd);
      tab_y0[4] = 16'(-5120 + int'(rnd % 32'd4096));
      rnd = xorshift(rnd);
      tab_step[4] = 16'(256 + int'(rnd % 32'd1024));
      tab_name[4] = "random";
      tab_inside[4] = -1;
      tab_restart[4] = 1'b0;
      repeat (2) @(posedge i_clk);
      check_value("reset", "busy", 0, int'(o_busy));
      check_value("reset", "pix valid", 0, int'(o_pix_valid));
      check_value("reset", "frame done", 0, int'(o_frame_done));
      check_value("reset", "inside count", 0, int'(o_inside_count));
      $display("Reset: %0d errors", frame_errors);
      #2;
      i_nrst = 1'b1;
      for (int f = 0; f < NUM_FRAMES; f++) begin
         run_frame(f);
      end
      $display("Frames run %0d, errors %0d, cycles %0d", NUM_FRAMES, errors, cycles);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
common/mandel_pkg.sv
design/escape_core.sv
design/pixel_scanner.sv
design/result_stage.sv
design/mandel_top.sv
testbench/mandel_chk.sv
testbench/tb_mandel.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mandel
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
